/* common/board_pkg.sv */
// ########################################
// shared types and constants of the board
// support frame. modules refer to them by
// scoped name, e.g. board_pkg::key_vec_t
// ########################################
`default_nettype none

package board_pkg;

    // one joystick vector, one bit per button
    localparam int JOY_W   = 10;
    // word address msb index of the rom space
    localparam int ROM_WAW = 21;

    // decoded keyboard keys, packed in one 32-bit word
    // joy1 sits in the lsbs, bit 31 is a zero pad
    typedef struct packed {
        logic             spare;
        logic [3:0]       gfx;
        logic             service;
        logic             pause;
        logic             reset;
        logic [1:0]       coin;
        logic [1:0]       start;
        logic [JOY_W-1:0] joy2;
        logic [JOY_W-1:0] joy1;
    } key_vec_t;

    // conditioned inputs as the game sees them
    typedef struct packed {
        logic [JOY_W-1:0] joy1;
        logic [JOY_W-1:0] joy2;
        logic [1:0]       coin;
        logic [1:0]       start;
        logic             service;
        logic [3:0]       gfx_en;
    } game_in_t;

    // osd settings unpacked from the status word
    typedef struct packed {
        logic       flip;
        logic       test;
        logic       pause_en;
        logic [1:0] fxlevel;
        logic [1:0] scanlines;
        logic [1:0] rotate;
        logic       vertical_n;
        logic       en_mixing;
        logic       enable_fm;
        logic       enable_psg;
    } dip_cfg_t;

    // game read request, byte address
    typedef struct packed {
        logic [ROM_WAW:0] addr;
    } rom_rd_req_t;

    // one download write
    // mask bit 0 -> low lane, bit 1 -> high lane
    typedef struct packed {
        logic [ROM_WAW:0] addr;
        logic [7:0]       data;
        logic [1:0]       mask;
        logic             we;
    } prog_wr_t;

    // read return, rdy pulses once per granted read
    typedef struct packed {
        logic [15:0] data;
        logic        rdy;
    } rom_rsp_t;

endpackage

`default_nettype wire

/* design/reset_seq.sv */
// ########################################
// core reset stretcher. any trigger reloads
// the counter, core_rst stays high until it
// has counted down RST_CYCLES cycles
// ########################################
`timescale 1ns/1ps
`default_nettype none

module reset_seq #(
    parameter int RST_CYCLES = 16
) (
    input  wire  clk_sys,
    input  wire  game_rst,
    input  wire  rst_req,
    input  wire  downloading,
    input  wire  flip,
    input  wire  soft_rst,
    output logic core_rst
);

    localparam int CW = $clog2(RST_CYCLES + 1);

    logic [CW-1:0] cnt;
    logic          last_flip;
    logic          trig;

    // a flip change means the game must restart
    // with the new screen orientation
    assign trig = game_rst | rst_req | downloading | soft_rst | (flip != last_flip);

    always_ff @(posedge clk_sys) begin
        last_flip <= flip;
        // reload on trigger, board reset included
        if (trig) begin
            cnt <= CW'(RST_CYCLES);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    // high for exactly RST_CYCLES after the last trigger
    assign core_rst = (cnt != '0);

    // every trigger is seen one cycle later with a full count
    a_trig_reload: assert property (
        @(posedge clk_sys) trig |=> (core_rst && cnt == CW'(RST_CYCLES))
    );

endmodule

`default_nettype wire

/* inputs/input_cond.sv */
// ########################################
// player input conditioning. syncs board
// joysticks, merges keyboard keys, applies
// polarity, toggles pause and gfx layers
// and makes the soft reset pulse
// ########################################
`timescale 1ns/1ps
`default_nettype none

module input_cond #(
    parameter int THREE_BUTTONS = 0,
    parameter bit ACTIVE_LOW    = 1'b1
) (
    input  wire                            clk_sys,
    input  wire                            core_rst,
    input  wire board_pkg::key_vec_t       keys,
    input  wire [board_pkg::JOY_W-1:0]     board_joy1,
    input  wire [board_pkg::JOY_W-1:0]     board_joy2,
    output board_pkg::game_in_t            game_in,
    output logic                           game_pause,
    output logic                           soft_rst
);

    // button positions shift up by one on three-button games
    localparam int COIN_BIT  = 6 + THREE_BUTTONS;
    localparam int START_BIT = 7 + THREE_BUTTONS;
    localparam int PAUSE_BIT = 8 + THREE_BUTTONS;

    logic [board_pkg::JOY_W-1:0] joy1_sync;
    logic [board_pkg::JOY_W-1:0] joy2_sync;
    board_pkg::key_vec_t         keys_sync;
    logic                        joy_pause;
    logic                        last_key_pause;
    logic                        last_joy_pause;
    logic                        last_key_reset;
    logic [3:0]                  last_gfx;
    logic [board_pkg::JOY_W-1:0] joy1_q;
    logic [board_pkg::JOY_W-1:0] joy2_q;
    logic [1:0]                  coin_q;
    logic [1:0]                  start_q;
    logic                        service_q;
    logic [3:0]                  gfx_en_q;
    logic                        pause_rise;
    logic [3:0]                  gfx_rise;

    // single sync stage, keys too so both paths line up
    always_ff @(posedge clk_sys) begin
        joy1_sync <= board_joy1;
        joy2_sync <= board_joy2;
        keys_sync <= keys;
    end

    // pause from either stick
    assign joy_pause = joy1_sync[PAUSE_BIT] | joy2_sync[PAUSE_BIT];

    // edge history keeps running in reset
    // so a key held through reset does not toggle
    always_ff @(posedge clk_sys) begin
        last_key_pause <= keys_sync.pause;
        last_joy_pause <= joy_pause;
        last_key_reset <= keys_sync.reset;
        last_gfx       <= keys_sync.gfx;
    end

    assign pause_rise = (keys_sync.pause & ~last_key_pause) | (joy_pause & ~last_joy_pause);
    assign gfx_rise   = keys_sync.gfx & ~last_gfx;

    // merged buttons, inverted for active low games
    always_ff @(posedge clk_sys) begin
        joy1_q  <= {board_pkg::JOY_W{ACTIVE_LOW}} ^ (joy1_sync | keys_sync.joy1);
        joy2_q  <= {board_pkg::JOY_W{ACTIVE_LOW}} ^ (joy2_sync | keys_sync.joy2);
        coin_q  <= {2{ACTIVE_LOW}} ^
                   ({joy2_sync[COIN_BIT], joy1_sync[COIN_BIT]} | keys_sync.coin);
        start_q <= {2{ACTIVE_LOW}} ^
                   ({joy2_sync[START_BIT], joy1_sync[START_BIT]} | keys_sync.start);
    end

    // state bits, cleared while the core is in reset
    always_ff @(posedge clk_sys) begin
        if (core_rst) begin
            game_pause <= 1'b0;
            soft_rst   <= 1'b0;
            service_q  <= ACTIVE_LOW;
            gfx_en_q   <= 4'hf;
        end else begin
            if (pause_rise) begin
                game_pause <= ~game_pause;
            end
            soft_rst  <= keys_sync.reset & ~last_key_reset;
            service_q <= keys_sync.service ^ ACTIVE_LOW;
            // each layer flips on its own key
            gfx_en_q  <= gfx_en_q ^ gfx_rise;
        end
    end

    assign game_in = '{
        joy1:    joy1_q,
        joy2:    joy2_q,
        coin:    coin_q,
        start:   start_q,
        service: service_q,
        gfx_en:  gfx_en_q
    };

    // soft reset is a single pulse, the stretch is done in reset_seq
    a_soft_rst_pulse: assert property (@(posedge clk_sys) soft_rst |=> !soft_rst);

endmodule

`default_nettype wire

/* design/dip_decode.sv */
// ########################################
// osd status word decode. one register
// stage between status and the settings
// ########################################
`timescale 1ns/1ps
`default_nettype none

module dip_decode (
    input  wire                  clk_sys,
    input  wire [31:0]           status,
    output board_pkg::dip_cfg_t  dip
);

    // bit 0 is the osd reset, handled elsewhere
    always_ff @(posedge clk_sys) begin
        dip.flip       <= status[1];
        dip.test       <= status[2];
        dip.pause_en   <= status[3];
        dip.fxlevel    <= status[5:4];
        dip.scanlines  <= status[7:6];
        dip.rotate     <= status[9:8];
        dip.vertical_n <= status[10];
        dip.en_mixing  <= status[11];
        // sound enables are stored as disables
        dip.enable_fm  <= ~status[12];
        dip.enable_psg <= ~status[13];
    end

endmodule

`default_nettype wire

/* rom/rom_arbiter.sv */
// ########################################
// shared rom port arbiter. downloader wins,
// then cpu, then gfx. read data comes back
// two cycles after the ack, in grant order
// ########################################
`timescale 1ns/1ps
`default_nettype none

module rom_arbiter (
    input  wire                            clk_sys,
    input  wire                            core_rst,
    input  wire                            downloading,
    input  wire board_pkg::prog_wr_t       prog,
    input  wire                            cpu_req,
    input  wire board_pkg::rom_rd_req_t    cpu_rd,
    input  wire                            gfx_req,
    input  wire board_pkg::rom_rd_req_t    gfx_rd,
    input  wire [15:0]                     mem_rdata,
    output logic                           cpu_ack,
    output logic                           gfx_ack,
    output board_pkg::rom_rsp_t            cpu_rsp,
    output board_pkg::rom_rsp_t            gfx_rsp,
    output logic [1:0]                     mem_we,
    output logic [board_pkg::ROM_WAW-1:0]  mem_addr,
    output logic [15:0]                    mem_wdata
);

    logic        rd_block;
    logic        tag_cpu;
    logic        tag_gfx;
    logic        cpu_rdy;
    logic        gfx_rdy;
    logic [15:0] rsp_data;

    // no reads while loading or while the core sits in reset
    assign rd_block = core_rst | downloading | prog.we;

    // fixed priority, cpu over gfx
    assign cpu_ack = cpu_req & ~rd_block;
    assign gfx_ack = gfx_req & ~cpu_req & ~rd_block;

    // same byte on both lanes, mask picks the lane
    assign mem_wdata = {2{prog.data}};

    // one access per cycle on the store port
    always_comb begin
        mem_we   = 2'b00;
        mem_addr = gfx_rd.addr[board_pkg::ROM_WAW:1];
        if (prog.we) begin
            mem_we   = prog.mask;
            mem_addr = prog.addr[board_pkg::ROM_WAW:1];
        end else if (cpu_req) begin
            mem_addr = cpu_rd.addr[board_pkg::ROM_WAW:1];
        end
    end

    // tag pipeline follows the store read latency
    // stage 1 is the store register, stage 2 the response
    always_ff @(posedge clk_sys) begin
        if (core_rst) begin
            tag_cpu <= 1'b0;
            tag_gfx <= 1'b0;
            cpu_rdy <= 1'b0;
            gfx_rdy <= 1'b0;
        end else begin
            tag_cpu <= cpu_ack;
            tag_gfx <= gfx_ack;
            cpu_rdy <= tag_cpu;
            gfx_rdy <= tag_gfx;
        end
    end

    // data reg is shared, only rdy tells the owner
    always_ff @(posedge clk_sys) begin
        rsp_data <= mem_rdata;
    end

    assign cpu_rsp = '{data: rsp_data, rdy: cpu_rdy};
    assign gfx_rsp = '{data: rsp_data, rdy: gfx_rdy};

    a_one_ack: assert property (@(posedge clk_sys) !(cpu_ack && gfx_ack));

    a_no_ack_dl: assert property (
        @(posedge clk_sys) downloading |-> !(cpu_ack || gfx_ack)
    );

endmodule

`default_nettype wire

/* rom/rom_store.sv */
// ########################################
// on-chip rom store, 16-bit words with two
// byte lanes. reads every cycle, data is
// registered and valid one cycle later
// ########################################
`timescale 1ns/1ps
`default_nettype none

module rom_store #(
    parameter int AW = 10
) (
    input  wire           clk_sys,
    input  wire  [1:0]    we,
    input  wire  [AW-1:0] addr,
    input  wire  [15:0]   wdata,
    output logic [15:0]   rdata
);

    // lane 0 is the low byte
    logic [1:0][7:0] mem [0:(2**AW)-1];

    // byte lane writes
    always_ff @(posedge clk_sys) begin
        if (we[0]) begin
            mem[addr][0] <= wdata[7:0];
        end
        if (we[1]) begin
            mem[addr][1] <= wdata[15:8];
        end
    end

    // old data on a same-address write
    always_ff @(posedge clk_sys) begin
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

/* design/board_top.sv */
// ########################################
// board support top. reset stretch, input
// conditioning, dip decode and the shared
// rom path, parameters set here
// ########################################
`timescale 1ns/1ps
`default_nettype none

module board_top #(
    parameter int THREE_BUTTONS = 0,
    parameter bit ACTIVE_LOW    = 1'b1,
    parameter int RST_CYCLES    = 16,
    parameter int ROM_AW        = 10
) (
    input  wire                            clk_sys,
    input  wire                            game_rst,
    input  wire                            rst_req,
    input  wire                            downloading,
    input  wire board_pkg::prog_wr_t       prog,
    input  wire board_pkg::key_vec_t       keys,
    input  wire [board_pkg::JOY_W-1:0]     board_joy1,
    input  wire [board_pkg::JOY_W-1:0]     board_joy2,
    input  wire [31:0]                     status,
    input  wire                            cpu_req,
    input  wire board_pkg::rom_rd_req_t    cpu_rd,
    input  wire                            gfx_req,
    input  wire board_pkg::rom_rd_req_t    gfx_rd,
    output logic                           core_rst,
    output board_pkg::game_in_t            game_in,
    output logic                           game_pause,
    output board_pkg::dip_cfg_t            dip,
    output logic                           dip_pause,
    output logic                           cpu_ack,
    output logic                           gfx_ack,
    output board_pkg::rom_rsp_t            cpu_rsp,
    output board_pkg::rom_rsp_t            gfx_rsp
);

    logic                          soft_rst;
    logic                          blk_rst;
    logic [1:0]                    mem_we;
    logic [board_pkg::ROM_WAW-1:0] mem_addr;
    logic [15:0]                   mem_wdata;
    logic [15:0]                   mem_rdata;

    // blocks also clear in the first board reset cycle
    assign blk_rst = core_rst | game_rst;

    // pause only counts when the osd allows it
    assign dip_pause = dip.pause_en & game_pause;

    reset_seq #(
        .RST_CYCLES (RST_CYCLES)
    ) reset_seq_inst (
        .clk_sys     (clk_sys),
        .game_rst    (game_rst),
        .rst_req     (rst_req),
        .downloading (downloading),
        .flip        (dip.flip),
        .soft_rst    (soft_rst),
        .core_rst    (core_rst)
    );

    input_cond #(
        .THREE_BUTTONS (THREE_BUTTONS),
        .ACTIVE_LOW    (ACTIVE_LOW)
    ) input_cond_inst (
        .clk_sys    (clk_sys),
        .core_rst   (blk_rst),
        .keys       (keys),
        .board_joy1 (board_joy1),
        .board_joy2 (board_joy2),
        .game_in    (game_in),
        .game_pause (game_pause),
        .soft_rst   (soft_rst)
    );

    dip_decode dip_decode_inst (
        .clk_sys (clk_sys),
        .status  (status),
        .dip     (dip)
    );

    rom_arbiter rom_arbiter_inst (
        .clk_sys     (clk_sys),
        .core_rst    (blk_rst),
        .downloading (downloading),
        .prog        (prog),
        .cpu_req     (cpu_req),
        .cpu_rd      (cpu_rd),
        .gfx_req     (gfx_req),
        .gfx_rd      (gfx_rd),
        .mem_rdata   (mem_rdata),
        .cpu_ack     (cpu_ack),
        .gfx_ack     (gfx_ack),
        .cpu_rsp     (cpu_rsp),
        .gfx_rsp     (gfx_rsp),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata)
    );

    // store only decodes the low word address bits
    rom_store #(
        .AW (ROM_AW)
    ) rom_store_inst (
        .clk_sys (clk_sys),
        .we      (mem_we),
        .addr    (mem_addr[ROM_AW-1:0]),
        .wdata   (mem_wdata),
        .rdata   (mem_rdata)
    );

endmodule

`default_nettype wire

/* tb/board_tb_ref.svh */
// ########################################
// reference model for the board testbench
// xorshift source, expected input merge,
// expected dip decode and rom shadow copy
// ########################################
`ifndef BOARD_TB_REF_SVH
`define BOARD_TB_REF_SVH

// random source state, fixed seed
logic [31:0] rng_state = 32'hc352_bb16;

// shadow of the rom words as the testbench wrote them
logic [15:0] shadow [0:1023];

function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

function automatic logic [31:0] next_rand();
    rng_state = xorshift(rng_state);
    return rng_state;
endfunction

// conditioned inputs for one key and joystick set
// gfx_en is state, left at zero and not compared
function automatic board_pkg::game_in_t merge_inputs(input board_pkg::key_vec_t k,
                                                    input logic [9:0] j1,
                                                    input logic [9:0] j2);
    board_pkg::game_in_t g;
    g         = '0;
    g.joy1    = (j1 | k.joy1) ^ {10{ACTIVE_LOW}};
    g.joy2    = (j2 | k.joy2) ^ {10{ACTIVE_LOW}};
    g.coin[0] = (j1[6 + THREE_BUTTONS] | k.coin[0]) ^ ACTIVE_LOW;
    g.coin[1] = (j2[6 + THREE_BUTTONS] | k.coin[1]) ^ ACTIVE_LOW;
    g.start[0] = (j1[7 + THREE_BUTTONS] | k.start[0]) ^ ACTIVE_LOW;
    g.start[1] = (j2[7 + THREE_BUTTONS] | k.start[1]) ^ ACTIVE_LOW;
    g.service = k.service ^ ACTIVE_LOW;
    return g;
endfunction

// status word to settings, sound enables are inverted
function automatic board_pkg::dip_cfg_t decode_status(input logic [31:0] s);
    board_pkg::dip_cfg_t d;
    d.flip       = s[1];
    d.test       = s[2];
    d.pause_en   = s[3];
    d.fxlevel    = s[5:4];
    d.scanlines  = s[7:6];
    d.rotate     = s[9:8];
    d.vertical_n = s[10];
    d.en_mixing  = s[11];
    d.enable_fm  = !s[12];
    d.enable_psg = !s[13];
    return d;
endfunction

// byte write into the shadow, word index from addr[10:1]
function automatic void shadow_write(input logic [21:0] a, input logic [7:0] d,
                                     input logic [1:0] m);
    if (m[0]) begin
        shadow[a[10:1]][7:0] = d;
    end
    if (m[1]) begin
        shadow[a[10:1]][15:8] = d;
    end
endfunction

`endif

/* tb/board_tb.sv */
// ########################################
// testbench for the board support top.
// reset stretch, input merge, toggles,
// soft reset, dip decode and rom sharing
// ########################################
`timescale 1ns/1ps
`default_nettype none

module board_tb;

    localparam int THREE_BUTTONS = 0;
    localparam bit ACTIVE_LOW    = 1'b1;
    localparam int RST_CYCLES    = 16;
    localparam int MERGE_N       = 200;
    localparam int DIP_N         = 60;
    localparam int FILL_N        = 1024;
    localparam int DL_N          = 300;
    localparam int RD_N          = 400;
    localparam int DRAIN_N       = 20;
    localparam int MAX_WAIT      = 64;
    // twice the sum of all phase lengths
    localparam int MAX_CYCLES = 2 * (8 * RST_CYCLES + MERGE_N + DIP_N + FILL_N + DL_N
                                     + RD_N + DRAIN_N + 100);

    typedef struct packed {
        logic                en;
        board_pkg::key_vec_t keys;
        logic [9:0]          j1;
        logic [9:0]          j2;
    } stim_t;

    logic                   clk_sys = 1'b0;
    logic                   game_rst;
    logic                   rst_req;
    logic                   downloading;
    board_pkg::prog_wr_t    prog;
    board_pkg::key_vec_t    keys;
    logic [9:0]             board_joy1;
    logic [9:0]             board_joy2;
    logic [31:0]            status;
    logic                   cpu_req;
    board_pkg::rom_rd_req_t cpu_rd;
    logic                   gfx_req;
    board_pkg::rom_rd_req_t gfx_rd;
    logic                   core_rst;
    board_pkg::game_in_t    game_in;
    logic                   game_pause;
    board_pkg::dip_cfg_t    dip;
    logic                   dip_pause;
    logic                   cpu_ack;
    logic                   gfx_ack;
    board_pkg::rom_rsp_t    cpu_rsp;
    board_pkg::rom_rsp_t    gfx_rsp;

    int                  errors = 0;
    int                  cycles = 0;
    int                  len;
    logic                chk_merge = 1'b0;
    logic                chk_dip = 1'b0;
    stim_t               stim_h0 = '0;
    stim_t               stim_h1 = '0;
    logic [31:0]         status_h = '0;
    logic                dip_en_h = 1'b0;
    board_pkg::game_in_t exp_in;
    logic                exp_pause;
    logic [3:0]          exp_gfx;
    logic [31:0]         r;
    logic                c_req_m;
    logic                g_req_m;
    logic                c_acked;
    logic                g_acked;
    logic [9:0]          c_word;
    logic [9:0]          g_word;
    int                  c_wait;
    int                  g_wait;
    logic [1:0]          cq_ack;
    logic [1:0]          gq_ack;
    logic [9:0]          cq_addr [2];
    logic [9:0]          gq_addr [2];

    `include "board_tb_ref.svh"

    always #5 clk_sys = ~clk_sys;

    board_top #(
        .THREE_BUTTONS (THREE_BUTTONS),
        .ACTIVE_LOW    (ACTIVE_LOW),
        .RST_CYCLES    (RST_CYCLES),
        .ROM_AW        (10)
    ) board_top_inst (
        .clk_sys (clk_sys), .game_rst (game_rst), .rst_req (rst_req),
        .downloading (downloading), .prog (prog), .keys (keys),
        .board_joy1 (board_joy1), .board_joy2 (board_joy2), .status (status),
        .cpu_req (cpu_req), .cpu_rd (cpu_rd), .gfx_req (gfx_req), .gfx_rd (gfx_rd),
        .core_rst (core_rst), .game_in (game_in), .game_pause (game_pause),
        .dip (dip), .dip_pause (dip_pause), .cpu_ack (cpu_ack), .gfx_ack (gfx_ack),
        .cpu_rsp (cpu_rsp), .gfx_rsp (gfx_rsp)
    );

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic fail_note(input string what);
        errors++;
        $display("error: %s", what);
    endtask

    // counts negedges with core_rst high, from the current one on
    task automatic rst_length(output int n);
        n = 0;
        while (core_rst === 1'b1 && n < 4 * RST_CYCLES) begin
            n++;
            @(negedge clk_sys);
        end
    endtask

    // inputs as they were two edges back, and status one edge back
    always @(posedge clk_sys) begin
        stim_h1  <= stim_h0;
        stim_h0  <= '{en: chk_merge, keys: keys, j1: board_joy1, j2: board_joy2};
        status_h <= status;
        dip_en_h <= chk_dip;
    end

    // compare process for merged inputs and dip decode
    always @(negedge clk_sys) begin
        if (stim_h1.en) begin
            exp_in = merge_inputs(stim_h1.keys, stim_h1.j1, stim_h1.j2);
            check("game_in.joy1", 32'(game_in.joy1), 32'(exp_in.joy1));
            check("game_in.joy2", 32'(game_in.joy2), 32'(exp_in.joy2));
            check("game_in.coin", 32'(game_in.coin), 32'(exp_in.coin));
            check("game_in.start", 32'(game_in.start), 32'(exp_in.start));
            check("game_in.service", 32'(game_in.service), 32'(exp_in.service));
        end
        if (dip_en_h) begin
            check("dip", 32'(dip), 32'(decode_status(status_h)));
        end
    end

    always @(posedge clk_sys) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // edge on key pause or joystick pause, then hold and release
    // pause_en goes in through status bit 3
    task automatic press_pause(input bit use_joy, input bit pause_en);
        status[3] = pause_en;
        if (use_joy) begin
            board_joy1[8 + THREE_BUTTONS] = 1'b1;
        end else begin
            keys.pause = 1'b1;
        end
        repeat (2) @(negedge clk_sys);
        exp_pause = !exp_pause;
        check("game_pause", 32'(game_pause), 32'(exp_pause));
        check("dip_pause", 32'(dip_pause), 32'(exp_pause & pause_en));
        // held key must not toggle again
        repeat (3) @(negedge clk_sys);
        check("game_pause", 32'(game_pause), 32'(exp_pause));
        board_joy1 = '0;
        keys.pause = 1'b0;
        repeat (3) @(negedge clk_sys);
        check("game_pause", 32'(game_pause), 32'(exp_pause));
    endtask

    task automatic soft_reset();
        int n;
        keys.reset = 1'b1;
        n = 0;
        while (board_top_inst.soft_rst !== 1'b1 && n < 8) begin
            n++;
            @(negedge clk_sys);
        end
        if (n >= 8) begin
            fail_note("no soft reset pulse after the reset key");
        end
        keys.reset = 1'b0;
        @(negedge clk_sys);
        rst_length(n);
        check("core_rst length", n, RST_CYCLES);
        check("game_pause", 32'(game_pause), 32'h0);
        check("game_in.gfx_en", 32'(game_in.gfx_en), 32'hf);
        exp_pause = 1'b0;
        exp_gfx   = 4'hf;
    endtask

    initial begin
        game_rst = 1'b1;
        rst_req = 1'b0;
        downloading = 1'b0;
        prog = '0;
        keys = '0;
        board_joy1 = '0;
        board_joy2 = '0;
        status = '0;
        cpu_req = 1'b0;
        cpu_rd = '0;
        gfx_req = 1'b0;
        gfx_rd = '0;
        repeat (5) @(posedge clk_sys);
        @(negedge clk_sys);
        game_rst = 1'b0;
        rst_length(len);
        check("core_rst length", len, RST_CYCLES);

        // two requests, length counts from the second
        rst_req = 1'b1;
        @(negedge clk_sys);
        rst_req = 1'b0;
        repeat (5) @(negedge clk_sys);
        rst_req = 1'b1;
        @(negedge clk_sys);
        rst_req = 1'b0;
        rst_length(len);
        check("core_rst length", len, RST_CYCLES);

        // flip goes through dip_decode, one extra edge
        for (int f = 1; f >= 0; f--) begin
            status[1] = f[0];
            repeat (2) @(negedge clk_sys);
            rst_length(len);
            check("core_rst length", len, RST_CYCLES);
        end

        for (int i = 0; i < MERGE_N; i++) begin
            r = next_rand();
            keys = board_pkg::key_vec_t'(r);
            keys.spare = 1'b0;
            keys.reset = 1'b0;
            keys.pause = 1'b0;
            keys.gfx   = 4'h0;
            r = next_rand();
            board_joy1 = r[9:0];
            board_joy2 = r[25:16];
            chk_merge = 1'b1;
            @(negedge clk_sys);
        end
        chk_merge = 1'b0;
        keys = '0;
        board_joy1 = '0;
        board_joy2 = '0;

        for (int i = 0; i < DIP_N; i++) begin
            status = next_rand() & 32'hffff_fffd;
            chk_dip = 1'b1;
            @(negedge clk_sys);
        end
        chk_dip = 1'b0;
        status = 32'h0000_0008;
        repeat (4) @(negedge clk_sys);

        soft_reset();
        press_pause(1'b0, 1'b0);
        press_pause(1'b1, 1'b1);
        press_pause(1'b0, 1'b1);
        for (int g = 0; g < 4; g++) begin
            keys.gfx[g] = 1'b1;
            repeat (2) @(negedge clk_sys);
            exp_gfx[g] = !exp_gfx[g];
            check("game_in.gfx_en", 32'(game_in.gfx_en), 32'(exp_gfx));
            repeat (3) @(negedge clk_sys);
            keys.gfx[g] = 1'b0;
            check("game_in.gfx_en", 32'(game_in.gfx_en), 32'(exp_gfx));
        end
        repeat (2) @(negedge clk_sys);
        soft_reset();

        // download, both clients keep asking the whole time
        downloading = 1'b1;
        c_req_m = 1'b1;
        g_req_m = 1'b1;
        c_word = 10'd5;
        g_word = 10'd9;
        cpu_req = 1'b1;
        gfx_req = 1'b1;
        cpu_rd.addr = 22'({c_word, 1'b0});
        gfx_rd.addr = 22'({g_word, 1'b1});
        for (int i = 0; i < FILL_N + DL_N; i++) begin
            r = next_rand();
            if (i < FILL_N) begin
                prog = '{addr: 22'(i * 2), data: i[7:0] ^ {4{i[9:8]}}, mask: 2'b11, we: 1'b1};
            end else begin
                prog = '{addr: 22'(r[11:1]), data: r[19:12], mask: r[21:20], we: r[0]};
            end
            if (prog.we) begin
                shadow_write(prog.addr, prog.data, prog.mask);
            end
            #1;
            check("cpu_ack", 32'(cpu_ack), 32'h0);
            check("gfx_ack", 32'(gfx_ack), 32'h0);
            @(negedge clk_sys);
        end
        prog = '0;
        downloading = 1'b0;
        @(negedge clk_sys);
        len = 0;
        while (core_rst === 1'b1 && len < 4 * RST_CYCLES) begin
            check("cpu_ack", 32'(cpu_ack), 32'h0);
            len++;
            @(negedge clk_sys);
        end

        c_acked = 1'b0;
        g_acked = 1'b0;
        c_wait = 0;
        g_wait = 0;
        cq_ack = '0;
        gq_ack = '0;
        for (int i = 0; i < RD_N + DRAIN_N; i++) begin
            check("cpu_rsp.rdy", 32'(cpu_rsp.rdy), 32'(cq_ack[1]));
            check("gfx_rsp.rdy", 32'(gfx_rsp.rdy), 32'(gq_ack[1]));
            if (cq_ack[1]) begin
                check("cpu_rsp.data", 32'(cpu_rsp.data), 32'(shadow[cq_addr[1]]));
            end
            if (gq_ack[1]) begin
                check("gfx_rsp.data", 32'(gfx_rsp.data), 32'(shadow[gq_addr[1]]));
            end
            cq_ack[1] = cq_ack[0];
            gq_ack[1] = gq_ack[0];
            cq_addr[1] = cq_addr[0];
            gq_addr[1] = gq_addr[0];
            r = next_rand();
            // new request only once the last one was taken
            if (c_acked || !c_req_m) begin
                c_req_m = (i < RD_N) && r[0];
                cpu_rd.addr = 22'(r[11:1]);
            end
            if (g_acked || !g_req_m) begin
                g_req_m = (i < RD_N) && (r[16] || r[17]);
                gfx_rd.addr = 22'(r[27:17]);
            end
            cpu_req = c_req_m;
            gfx_req = g_req_m;
            #1;
            check("cpu_ack", 32'(cpu_ack), 32'(c_req_m));
            check("gfx_ack", 32'(gfx_ack), 32'(g_req_m && !c_req_m));
            c_acked = c_req_m;
            g_acked = g_req_m && !c_req_m;
            cq_ack[0] = c_acked;
            gq_ack[0] = g_acked;
            cq_addr[0] = cpu_rd.addr[10:1];
            gq_addr[0] = gfx_rd.addr[10:1];
            g_wait = (g_req_m && !gfx_ack) ? g_wait + 1 : 0;
            c_wait = (c_req_m && !cpu_ack) ? c_wait + 1 : 0;
            if (g_wait == MAX_WAIT || c_wait == MAX_WAIT) begin
                fail_note("a read request waited too long for its ack");
            end
            @(negedge clk_sys);
        end
        if (c_req_m || g_req_m) begin
            fail_note("read requests still pending at the end");
        end

        $display("summary: %0d errors in %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+tb
common/board_pkg.sv
design/reset_seq.sv
inputs/input_cond.sv
design/dip_decode.sv
rom/rom_arbiter.sv
rom/rom_store.sv
design/board_top.sv
tb/board_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the board testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module board_tb \
    -f project.f

./obj_dir/Vboard_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^NO ERRORS$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
